// File: bench/tb_measure_core.sv
// Self-checking testbench for measure_core, compiled with the project file list and run as top
`timescale 1ns/1ps
`include "measure_macros.svh"

module tb_measure_core import measure_pkg::*; ();

  localparam mac_addr_t  local_mac      = `DEFAULT_MAC_ADDR;
  localparam ipv4_addr_t local_ip       = `DEFAULT_IPV4_ADDR;
  localparam int         rate_frames    = 6;
  localparam int         timeout_cycles = 2000;   // All tests take about 1400 cycles

  logic        gmii_tx_clk;
  logic        sys_rst;
  logic        sec_oneshot;
  counter_t    global_counter;
  byte_t       rx_data;
  logic        rx_dv;
  byte_t       gmii_txd;
  logic        gmii_tx_en;
  counter_t    rx_pps;
  counter_t    rx_throughput;
  latency_t    rx_latency;
  ipv4_addr_t  rx_ipv4_ip;

  logic [31:0] lfsr_state;
  counter_t    ts_free;                         // Free-running timestamp
  counter_t    ts_value;
  logic        ts_hold;
  byte_t       frame_buf [0:127];
  int          len_tab [0:rate_frames-1];
  byte_t       exp_reply [0:71];
  logic        reply_armed;
  int          tx_len;
  int          tx_bursts;
  logic        prev_en;
  int          value_errs;
  int          event_errs;
  int          cycles;

  assign global_counter = ts_hold ? ts_value : ts_free;

  measure_core #(
    .int_ipv4_addr (local_ip),
    .int_mac_addr  (local_mac)
  ) dut0 (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .sec_oneshot    (sec_oneshot),
    .global_counter (global_counter),
    .rx_data        (rx_data),
    .rx_dv          (rx_dv),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .rx_pps         (rx_pps),
    .rx_throughput  (rx_throughput),
    .rx_latency     (rx_latency),
    .rx_ipv4_ip     (rx_ipv4_ip)
  );

  always #20 gmii_tx_clk = ~gmii_tx_clk;

  always @(negedge gmii_tx_clk)
    ts_free <= ts_free + 32'd1;

  // ------------------------------
  // Random source and references
  // ------------------------------
  // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = rand_bits(8);
    return r[7:0];
  endfunction

  function automatic latency_t latency_ref(input counter_t g, input counter_t t);
    counter_t d;
    d = g - t;
    return d[23:0];
  endfunction

  // Frame count in the upper half and byte count in the lower half
  function automatic logic [63:0] rate_ref(input int n);
    counter_t bytes;
    bytes = '0;
    for (int i = 0; i < n; i++)
      bytes = bytes + len_tab[i];
    return {n[31:0], bytes};
  endfunction

  function automatic void build_reply(input mac_addr_t mac, input ipv4_addr_t ip);
    logic [335:0] hdr;
    logic [31:0]  crc;
    logic         fb;
    hdr = {mac, local_mac, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'd2,
           local_mac, local_ip, mac, ip};
    crc = 32'hFFFFFFFF;
    for (int i = 0; i < 7; i++)
      exp_reply[i] = 8'h55;                     // Standard preamble then SFD
    exp_reply[7] = 8'hD5;
    for (int i = 0; i < 60; i++) begin
      exp_reply[8 + i] = (i < 42) ? hdr[335 - 8*i -: 8] : 8'h00;
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ exp_reply[8 + i][b];
        crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB88320 : 32'h00000000);
      end
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++)
      exp_reply[68 + i] = crc[8*i +: 8];        // FCS low byte first
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_counter(input string name, input counter_t exp, input counter_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input latency_t exp, input latency_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ip(input string name, input ipv4_addr_t exp, input ipv4_addr_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic fill_random(input int len);
    for (int i = 0; i < len; i++)
      frame_buf[i] = rand_byte();
    frame_buf[12] = 8'h08;                      // IPv4 ethertype so never ARP
    frame_buf[13] = 8'h00;
    frame_buf[42] = 8'h00;                      // Never a test frame
  endtask

  task automatic build_arp_frame(input logic [15:0] etype, input logic [15:0] opcode,
                                 input ipv4_addr_t target, input mac_addr_t mac,
                                 input ipv4_addr_t ip);
    logic [335:0] hdr;
    hdr = {48'hFFFF_FFFF_FFFF, mac, etype, 16'h0001, 16'h0800, 8'd6, 8'd4, opcode,
           mac, ip, 48'h0, target};
    for (int i = 0; i < 60; i++)
      frame_buf[i] = (i < 42) ? hdr[335 - 8*i -: 8] : 8'h00;
  endtask

  task automatic send_frame(input int len, input logic hold_ts);
    for (int i = 0; i < len; i++) begin
      @(negedge gmii_tx_clk);
      rx_dv   = 1'b1;
      rx_data = frame_buf[i];
      ts_hold = hold_ts && (i == `OFS_DECIDE);  // Known timestamp at decision byte
    end
    @(negedge gmii_tx_clk);
    rx_dv   = 1'b0;
    rx_data = 8'h00;
    ts_hold = 1'b0;
    repeat (12) @(negedge gmii_tx_clk);         // Inter-frame gap
  endtask

  task automatic pulse_second();
    @(negedge gmii_tx_clk);
    sec_oneshot = 1'b1;
    @(negedge gmii_tx_clk);
    sec_oneshot = 1'b0;
  endtask

  task automatic expect_silence(input string what);
    logic seen;
    seen = 1'b0;
    repeat (100) begin
      @(negedge gmii_tx_clk);
      if (gmii_tx_en && !seen) begin
        seen = 1'b1;
        event_errs++;
        $display("A reply was transmitted for %s", what);
      end
    end
  endtask

  // Reply monitor that compares each transmitted byte
  always @(negedge gmii_tx_clk) begin
    if (gmii_tx_en) begin
      if (!prev_en)
        tx_bursts = tx_bursts + 1;
      if (reply_armed && tx_len < 72)
        check_byte($sformatf("arp reply byte %0d", tx_len), exp_reply[tx_len], gmii_txd);
      tx_len = tx_len + 1;
    end
    prev_en = gmii_tx_en;
  end

  always @(posedge gmii_tx_clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Checks stopped: %0d value errors, %0d other errors", value_errs, event_errs);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [63:0] rate_exp;
    logic [31:0] r;
    magic_t      magic_val;
    counter_t    t_stamp;
    counter_t    g_val;
    mac_addr_t   peer_mac;
    ipv4_addr_t  peer_ip;
    int          waited;

    gmii_tx_clk = 1'b0;
    sys_rst     = 1'b1;
    sec_oneshot = 1'b0;
    rx_data     = 8'h00;
    rx_dv       = 1'b0;
    ts_free     = '0;
    ts_value    = '0;
    ts_hold     = 1'b0;
    lfsr_state  = 32'h97f6;
    reply_armed = 1'b0;
    tx_len      = 0;
    tx_bursts   = 0;
    prev_en     = 1'b0;
    value_errs  = 0;
    event_errs  = 0;
    cycles      = 0;
    repeat (16) @(negedge gmii_tx_clk);
    sys_rst = 1'b0;
    @(negedge gmii_tx_clk);

    if (gmii_tx_en !== 1'b0) begin
      event_errs++;
      $display("gmii_tx_en is not low after reset");
    end
    check_counter("reset rx_pps", '0, rx_pps);
    check_counter("reset rx_throughput", '0, rx_throughput);
    check_latency("reset rx_latency", '0, rx_latency);
    check_ip("reset rx_ipv4_ip", '0, rx_ipv4_ip);

    pulse_second();                             // Open a fresh one-second window
    for (int i = 0; i < rate_frames; i++) begin
      r = rand_bits(6);
      len_tab[i] = 64 + int'(r % 37);
      fill_random(len_tab[i]);
      send_frame(len_tab[i], 1'b0);
    end
    pulse_second();
    rate_exp = rate_ref(rate_frames);
    check_counter("rate rx_pps", rate_exp[63:32], rx_pps);
    check_counter("rate rx_throughput", rate_exp[31:0], rx_throughput);

    fill_random(64);
    magic_val = `MAGIC_CODE;
    t_stamp   = rand_bits(32);
    g_val     = rand_bits(32);
    for (int i = 0; i < 5; i++)
      frame_buf[42 + i] = magic_val[39 - 8*i -: 8];
    for (int i = 0; i < 4; i++)
      frame_buf[47 + i] = t_stamp[31 - 8*i -: 8];
    ts_value = g_val;
    send_frame(64, 1'b1);
    check_latency("latency rx_latency", latency_ref(g_val, t_stamp), rx_latency);
    check_ip("latency rx_ipv4_ip",
             {frame_buf[30], frame_buf[31], frame_buf[32], frame_buf[33]}, rx_ipv4_ip);

    r = rand_bits(16);
    peer_mac[47:32] = r[15:0];
    peer_mac[31:0]  = rand_bits(32);
    peer_ip         = rand_bits(32);
    build_reply(peer_mac, peer_ip);
    build_arp_frame(`ETHTYPE_ARP, `ARP_OP_REQUEST, local_ip, peer_mac, peer_ip);
    tx_len      = 0;
    tx_bursts   = 0;
    reply_armed = 1'b1;
    send_frame(60, 1'b0);
    waited = 0;
    while ((tx_len < 72 || gmii_tx_en) && waited < 200) begin
      @(negedge gmii_tx_clk);
      waited++;
    end
    @(negedge gmii_tx_clk);
    if (tx_len == 0) begin
      event_errs++;
      $display("No ARP reply: gmii_tx_en never went high");
    end else if (tx_len != 72 || tx_bursts != 1) begin
      event_errs++;
      $display("ARP reply was %0d bytes in %0d bursts, expected 72 in one", tx_len, tx_bursts);
    end
    reply_armed = 1'b0;

    build_arp_frame(`ETHTYPE_ARP, `ARP_OP_REQUEST, local_ip ^ 32'h1, peer_mac, peer_ip);
    send_frame(60, 1'b0);
    expect_silence("an ARP request to another IP");
    build_arp_frame(`ETHTYPE_ARP, `ARP_OP_REPLY, local_ip, peer_mac, peer_ip);
    send_frame(60, 1'b0);
    expect_silence("an ARP reply opcode");
    build_arp_frame(`ETHTYPE_IPV4, `ARP_OP_REQUEST, local_ip, peer_mac, peer_ip);
    send_frame(60, 1'b0);
    expect_silence("a non-ARP ethertype");

    $display("Checks done: %0d value errors, %0d other errors", value_errs, event_errs);
    if (value_errs == 0 && event_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+src
src/measure_pkg.sv
src/rx_frame_parser.sv
src/rx_rate_stats.sv
src/eth_fcs_crc32.sv
src/arp_reply_tx.sv
src/measure_core.sv
bench/tb_measure_core.sv

// File: src/arp_reply_tx.sv
// ARP reply transmitter that sends preamble, reply body, padding and FCS on GMII after each request
`timescale 1ns/1ps
`include "measure_macros.svh"

module arp_reply_tx import measure_pkg::*; #(
  parameter mac_addr_t  local_mac  = `DEFAULT_MAC_ADDR,
  parameter ipv4_addr_t local_ipv4 = `DEFAULT_IPV4_ADDR
) (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  logic       arp_req,
  input  mac_addr_t  peer_mac,
  input  ipv4_addr_t peer_ip,
  output byte_t      gmii_txd,
  output logic       gmii_tx_en
);

  typedef enum logic {st_idle, st_send} tx_state_t;

  tx_state_t    state;
  logic [6:0]   tx_cnt;                   // Byte position within the 72
  mac_addr_t    dst_mac;
  ipv4_addr_t   dst_ip;
  logic [335:0] arp_hdr;                  // 42 header bytes with the first byte on top
  logic [335:0] hdr_shift;
  logic [6:0]   body_idx;
  logic [6:0]   fcs_off;
  byte_t        body_byte;
  byte_t        fcs_byte;
  byte_t        next_txd;
  logic         crc_init;
  logic         crc_data_en;
  logic [1:0]   fcs_index;

  // ------------------------------
  // Reply body
  // ------------------------------
  assign arp_hdr = {dst_mac, local_mac, `ETHTYPE_ARP,
                    `ARP_HTYPE_ETH, `ETHTYPE_IPV4, `ARP_HLEN, `ARP_PLEN,
                    `ARP_OP_REPLY, local_mac, local_ipv4,
                    dst_mac, dst_ip};

  assign body_idx  = tx_cnt - `TX_BODY_START;
  assign hdr_shift = arp_hdr << {body_idx, 3'b000};
  assign body_byte = hdr_shift[335:328];  // Zero past byte 41 gives the padding

  assign fcs_off   = tx_cnt - `TX_FCS_START;
  assign fcs_index = fcs_off[1:0];

  assign crc_init    = (state == st_send) && (tx_cnt == `TX_BODY_START - 7'd1);
  assign crc_data_en = (state == st_send) && (tx_cnt >= `TX_BODY_START) &&
                       (tx_cnt < `TX_FCS_START);

  eth_fcs_crc32 u_fcs (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .crc_data_en (crc_data_en),
    .crc_byte    (body_byte),
    .fcs_index   (fcs_index),
    .fcs_byte    (fcs_byte)
  );

  always_comb begin
    if (tx_cnt < `TX_BODY_START - 7'd1)
      next_txd = `PREAMBLE_BYTE;
    else if (tx_cnt == `TX_BODY_START - 7'd1)
      next_txd = `SFD_BYTE;
    else if (tx_cnt < `TX_FCS_START)
      next_txd = body_byte;
    else
      next_txd = fcs_byte;
  end

  // Target is frozen for the whole reply
  always_ff @(posedge gmii_tx_clk) begin
    if (state == st_idle && arp_req) begin
      dst_mac <= peer_mac;
      dst_ip  <= peer_ip;
    end
  end

  // ------------------------------
  // Send sequencer
  // ------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state      <= st_idle;
      tx_cnt     <= '0;
      gmii_txd   <= '0;
      gmii_tx_en <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          gmii_txd   <= '0;
          gmii_tx_en <= 1'b0;
          if (arp_req) begin
            state  <= st_send;
            tx_cnt <= '0;
          end
        end
        st_send: begin
          if (tx_cnt == `TX_FRAME_BYTES) begin
            gmii_txd   <= '0;             // Requests during send were dropped
            gmii_tx_en <= 1'b0;
            state      <= st_idle;
          end else begin
            gmii_txd   <= next_txd;
            gmii_tx_en <= 1'b1;
            tx_cnt     <= tx_cnt + 7'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: src/eth_fcs_crc32.sv
// Byte-wide Ethernet CRC-32 that is fed body bytes and read back as FCS bytes in wire order
`timescale 1ns/1ps
`include "measure_macros.svh"

module eth_fcs_crc32 import measure_pkg::*; (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  logic       crc_init,
  input  logic       crc_data_en,
  input  byte_t      crc_byte,
  input  logic [1:0] fcs_index,
  output byte_t      fcs_byte
);

  logic [31:0] crc_q;                     // Running reflected remainder

  // One byte through the reflected polynomial LSB first
  function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input byte_t data);
    logic [31:0] c;
    c = crc ^ {24'h000000, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0])
        c = (c >> 1) ^ `CRC32_POLY_REFL;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst)
      crc_q <= `CRC32_INIT;
    else if (crc_init)
      crc_q <= `CRC32_INIT;               // Start of a new body
    else if (crc_data_en)
      crc_q <= crc32_byte(crc_q, crc_byte);
  end

  // Final inversion with index 0 as the first byte on the wire
  assign fcs_byte = ~crc_q[{fcs_index, 3'b000} +: 8];

endmodule

// File: src/measure_core.sv
// Top of the GMII measurement core with frame parser, per-second statistics and ARP responder
`timescale 1ns/1ps
`include "measure_macros.svh"

module measure_core import measure_pkg::*; #(
  parameter ipv4_addr_t int_ipv4_addr = `DEFAULT_IPV4_ADDR,
  parameter mac_addr_t  int_mac_addr  = `DEFAULT_MAC_ADDR
) (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  logic       sec_oneshot,
  input  counter_t   global_counter,
  input  byte_t      rx_data,             // Frame bytes after SFD
  input  logic       rx_dv,
  output byte_t      gmii_txd,
  output logic       gmii_tx_en,
  output counter_t   rx_pps,
  output counter_t   rx_throughput,
  output latency_t   rx_latency,
  output ipv4_addr_t rx_ipv4_ip
);

  logic       frame_start;
  logic       frame_end;
  frame_len_t frame_len;
  logic       arp_req;
  mac_addr_t  peer_mac;
  ipv4_addr_t peer_ip;

  // ------------------------------
  // Receive side
  // ------------------------------
  rx_frame_parser #(
    .local_ipv4 (int_ipv4_addr)
  ) u_parser (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .rx_data        (rx_data),
    .rx_dv          (rx_dv),
    .global_counter (global_counter),
    .frame_start    (frame_start),
    .frame_end      (frame_end),
    .frame_len      (frame_len),
    .rx_latency     (rx_latency),
    .rx_ipv4_ip     (rx_ipv4_ip),
    .arp_req        (arp_req),
    .peer_mac       (peer_mac),
    .peer_ip        (peer_ip)
  );

  rx_rate_stats u_stats (
    .gmii_tx_clk   (gmii_tx_clk),
    .sys_rst       (sys_rst),
    .sec_oneshot   (sec_oneshot),
    .frame_start   (frame_start),
    .frame_end     (frame_end),
    .frame_len     (frame_len),
    .rx_pps        (rx_pps),
    .rx_throughput (rx_throughput)
  );

  // ------------------------------
  // Transmit side
  // ------------------------------
  arp_reply_tx #(
    .local_mac  (int_mac_addr),
    .local_ipv4 (int_ipv4_addr)
  ) u_arp_tx (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .arp_req     (arp_req),
    .peer_mac    (peer_mac),
    .peer_ip     (peer_ip),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en)
  );

endmodule

// File: src/measure_macros.svh
// Shared constants for the GMII measurement core and its testbench that are pulled in by `include
`ifndef MEASURE_MACROS_SVH
`define MEASURE_MACROS_SVH

// ------------------------------
// Test frame
// ------------------------------
`define MAGIC_CODE          40'hA5C396E17B

// Receive byte offsets from destination MAC byte 0
`define OFS_SRC_MAC         16'd6
`define OFS_ETHTYPE         16'd12
`define OFS_ARP_OPCODE      16'd20
`define OFS_ARP_SRC_IP      16'd28
`define OFS_IP_DST          16'd30
`define OFS_ARP_DST_IP      16'd38
`define OFS_MAGIC           16'd42
`define OFS_TSTAMP          16'd47
`define OFS_DECIDE          16'd51

// ------------------------------
// ARP field values
// ------------------------------
`define ETHTYPE_ARP         16'h0806
`define ETHTYPE_IPV4        16'h0800
`define ARP_HTYPE_ETH       16'h0001
`define ARP_HLEN            8'd6
`define ARP_PLEN            8'd4
`define ARP_OP_REQUEST      16'd1
`define ARP_OP_REPLY        16'd2

// Transmit framing in bytes from the first preamble byte
`define PREAMBLE_BYTE       8'h55
`define SFD_BYTE            8'hD5
`define TX_BODY_START       7'd8
`define TX_FCS_START        7'd68
`define TX_FRAME_BYTES      7'd72
`define CRC32_POLY_REFL     32'hEDB88320
`define CRC32_INIT          32'hFFFFFFFF

// Local station defaults at 10.0.21.105
`define DEFAULT_MAC_ADDR    48'h003776_000101
`define DEFAULT_IPV4_ADDR   32'h0A00_1569

`endif

// File: src/measure_pkg.sv
// Scalar types shared by the measurement core modules and taken in by a wildcard import
package measure_pkg;

  // One GMII byte
  typedef logic [7:0]  byte_t;

  // Ethernet and IPv4 addresses
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  // ------------------------------
  // Counters and results
  // ------------------------------
  typedef logic [31:0] counter_t;        // Per-second counts and timestamp
  typedef logic [23:0] latency_t;        // Low bits of timestamp difference
  typedef logic [15:0] frame_len_t;      // Byte index and frame length

  // Test frame signature
  typedef logic [39:0] magic_t;

endpackage

// File: src/rx_frame_parser.sv
// Receive byte parser that counts frame bytes, extracts header fields and flags test and ARP frames
`timescale 1ns/1ps
`include "measure_macros.svh"

module rx_frame_parser import measure_pkg::*; #(
  parameter ipv4_addr_t local_ipv4 = `DEFAULT_IPV4_ADDR
) (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  byte_t      rx_data,
  input  logic       rx_dv,
  input  counter_t   global_counter,
  output logic       frame_start,
  output logic       frame_end,
  output frame_len_t frame_len,
  output latency_t   rx_latency,
  output ipv4_addr_t rx_ipv4_ip,
  output logic       arp_req,
  output mac_addr_t  peer_mac,
  output ipv4_addr_t peer_ip
);

  frame_len_t  rx_count;                  // Index of the byte being sampled
  mac_addr_t   src_mac;
  logic [15:0] eth_type;
  logic [15:0] arp_opcode;
  ipv4_addr_t  arp_src_ip;
  ipv4_addr_t  ip_dst;
  ipv4_addr_t  arp_dst_ip;
  magic_t      magic;
  counter_t    tstamp;
  counter_t    lat_diff;
  logic        decide;
  logic        is_test;
  logic        is_arp_req;

  // True when idx falls inside a field of len bytes at ofs
  function automatic logic in_field(frame_len_t idx, frame_len_t ofs, frame_len_t len);
    return (idx >= ofs) && (idx < ofs + len);
  endfunction

  assign lat_diff   = global_counter - tstamp;
  assign decide     = rx_dv && (rx_count == `OFS_DECIDE);
  assign is_test    = (magic == `MAGIC_CODE);
  assign is_arp_req = (eth_type == `ETHTYPE_ARP) &&
                      (arp_opcode == `ARP_OP_REQUEST) &&
                      (arp_dst_ip == local_ipv4);

  // ------------------------------
  // Field capture
  // ------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (rx_dv) begin
      if (in_field(rx_count, `OFS_SRC_MAC, 16'd6))
        src_mac <= {src_mac[39:0], rx_data};
      if (in_field(rx_count, `OFS_ETHTYPE, 16'd2))
        eth_type <= {eth_type[7:0], rx_data};
      if (in_field(rx_count, `OFS_ARP_OPCODE, 16'd2))
        arp_opcode <= {arp_opcode[7:0], rx_data};
      if (in_field(rx_count, `OFS_ARP_SRC_IP, 16'd4))
        arp_src_ip <= {arp_src_ip[23:0], rx_data};
      if (in_field(rx_count, `OFS_IP_DST, 16'd4))
        ip_dst <= {ip_dst[23:0], rx_data};      // Overlaps ARP sender IP
      if (in_field(rx_count, `OFS_ARP_DST_IP, 16'd4))
        arp_dst_ip <= {arp_dst_ip[23:0], rx_data};
      if (in_field(rx_count, `OFS_MAGIC, 16'd5))
        magic <= {magic[31:0], rx_data};
      if (in_field(rx_count, `OFS_TSTAMP, 16'd4))
        tstamp <= {tstamp[23:0], rx_data};
    end
    if (!rx_dv && rx_count != 16'd0)
      frame_len <= rx_count;                  // Length at frame end
    if (decide && !is_test && is_arp_req) begin
      peer_mac <= src_mac;                    // Requester becomes reply target
      peer_ip  <= arp_src_ip;
    end
  end

  // ------------------------------
  // Byte counter and decisions
  // ------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      rx_count    <= '0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      arp_req     <= 1'b0;
      rx_latency  <= '0;
      rx_ipv4_ip  <= '0;
    end else begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      arp_req     <= 1'b0;
      if (rx_dv) begin
        rx_count <= rx_count + 16'd1;
        if (rx_count == 16'd0)
          frame_start <= 1'b1;
        if (decide) begin
          if (is_test)
            rx_latency <= lat_diff[23:0];     // Wraps with the counter
          else if (is_arp_req)
            arp_req <= 1'b1;
        end
      end else if (rx_count != 16'd0) begin
        frame_end <= 1'b1;                    // rx_dv fell last cycle
        rx_count  <= '0;
      end
      // Destination IP is complete once byte 33 is in
      if (rx_count == `OFS_IP_DST + 16'd4)
        rx_ipv4_ip <= ip_dst;
    end
  end

endmodule

// File: src/rx_rate_stats.sv
// Per-second receive statistics that accumulate frames and bytes and publish them on each strobe
`timescale 1ns/1ps

module rx_rate_stats import measure_pkg::*; (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  logic       sec_oneshot,
  input  logic       frame_start,
  input  logic       frame_end,
  input  frame_len_t frame_len,
  output counter_t   rx_pps,
  output counter_t   rx_throughput
);

  counter_t pps_acc;                      // Frames this second
  counter_t byte_acc;                     // Bytes this second

  // ------------------------------
  // Accumulate and publish
  // ------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      pps_acc       <= '0;
      byte_acc      <= '0;
      rx_pps        <= '0;
      rx_throughput <= '0;
    end else if (sec_oneshot) begin
      // Publish and restart without counting events on this cycle
      rx_pps        <= pps_acc;
      rx_throughput <= byte_acc;
      pps_acc       <= '0;
      byte_acc      <= '0;
    end else begin
      if (frame_start)
        pps_acc <= pps_acc + 32'd1;
      if (frame_end)
        byte_acc <= byte_acc + {16'h0000, frame_len};
    end
  end

endmodule
